//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mcu16
FLIST     = flist.f
LOG       = sim.log
FAIL_MSG  = Checks failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
+incdir+testbench
hw/mcu16_pkg.sv
hw/mcu16_ifs.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/result_unit.sv
hw/mcu16_core.sv
testbench/tb_mcu16.sv

//--- hw/decode_unit.sv
`timescale 1ns/1ps

module decode_unit
    import mcu16_pkg::*;
(
    input  logic      clk,
    input  logic      nreset,
    input  word_t     instr_data,
    output pc_t       instr_addr,
    output reg_addr_t rs_addr,
    output reg_addr_t rd_addr,
    input  word_t     rs_data,
    input  word_t     rd_data,
    input  logic      pc_load,
    input  pc_t       pc_target,
    input  logic      stop,
    decode_if.source  dec
);
    seq_state_t state;
    pc_t        pc;
    opcode_t    opcode;
    word_t      imm_ext;
    alu_op_t    c_alu_op;
    logic       c_wr_en;
    logic       c_flags_en;
    logic       c_use_imm;
    logic       c_use_rd;
    logic       c_is_branch;
    logic       c_branch_neg;
    logic       c_is_out;
    logic       c_is_halt;
    logic       c_is_illegal;

    assign instr_addr = pc;
    assign opcode     = instr_data[WORD_W-1 -: OPCODE_W];
    assign rd_addr    = instr_data[RD_LSB +: REG_ADDR_W];
    assign rs_addr    = instr_data[RS_LSB +: REG_ADDR_W];
    assign imm_ext    = {{8{instr_data[7]}}, instr_data[7:0]};
    assign dec.valid  = (state == S_EXECUTE);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state <= S_DECODE;
            pc    <= RESET_PC;
        end else begin
            case (state)
                S_DECODE:  state <= S_EXECUTE;
                S_EXECUTE: state <= S_RESULT;
                S_RESULT: begin
                    // PC stays on the HLT or illegal word once the core stops
                    if (stop) begin
                        state <= S_STOPPED;
                    end else begin
                        state <= S_DECODE;
                        pc    <= pc_load ? pc_target : pc_t'(pc + 1'b1);
                    end
                end
                default: state <= S_STOPPED;
            endcase
        end
    end

    // Opcode to control table. Only ALU operations touch the flags
    always_comb begin
        c_alu_op     = ALU_PASS;
        c_wr_en      = 1'b0;
        c_flags_en   = 1'b0;
        c_use_imm    = 1'b0;
        c_use_rd     = 1'b0;
        c_is_branch  = 1'b0;
        c_branch_neg = 1'b0;
        c_is_out     = 1'b0;
        c_is_halt    = 1'b0;
        c_is_illegal = 1'b0;
        case (opcode)
            OP_NOP: ;
            OP_LDI: begin
                c_wr_en   = 1'b1;
                c_use_imm = 1'b1;
            end
            OP_MOV: c_wr_en = 1'b1;
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_SHL, OP_SHR, OP_INC, OP_DEC, OP_NOT, OP_NEG: begin
                c_wr_en    = 1'b1;
                c_flags_en = 1'b1;
                case (opcode)
                    OP_ADD:  c_alu_op = ALU_ADD;
                    OP_SUB:  c_alu_op = ALU_SUB;
                    OP_AND:  c_alu_op = ALU_AND;
                    OP_OR:   c_alu_op = ALU_OR;
                    OP_XOR:  c_alu_op = ALU_XOR;
                    OP_SHL:  c_alu_op = ALU_SHL;
                    OP_SHR:  c_alu_op = ALU_SHR;
                    OP_INC:  c_alu_op = ALU_INC;
                    OP_DEC:  c_alu_op = ALU_DEC;
                    OP_NOT:  c_alu_op = ALU_NOT;
                    default: c_alu_op = ALU_NEG;
                endcase
            end
            OP_CMP: begin
                c_alu_op   = ALU_SUB;
                c_flags_en = 1'b1;
            end
            OP_BR:  c_is_branch = 1'b1;
            OP_BRN: begin
                c_is_branch  = 1'b1;
                c_branch_neg = 1'b1;
            end
            // OUT emits rd through the pass path
            OP_OUT: begin
                c_is_out = 1'b1;
                c_use_rd = 1'b1;
            end
            OP_HLT:  c_is_halt = 1'b1;
            default: c_is_illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            dec.alu_op      <= c_alu_op;
            dec.operand_a   <= rd_data;
            dec.operand_b   <= c_use_imm ? imm_ext : (c_use_rd ? rd_data : rs_data);
            dec.rd          <= rd_addr;
            dec.wr_en       <= c_wr_en;
            dec.flags_en    <= c_flags_en;
            dec.is_branch   <= c_is_branch;
            dec.branch_neg  <= c_branch_neg;
            dec.branch_mask <= instr_data[RD_LSB +: FLAG_W];
            dec.target      <= pc_t'(pc + 1'b1 + instr_data[7:0]);
            dec.is_out      <= c_is_out;
            dec.is_halt     <= c_is_halt;
            dec.is_illegal  <= c_is_illegal;
        end
    end

    a_valid_single: assert property (@(posedge clk) disable iff (!nreset)
        dec.valid |=> !dec.valid);

endmodule

//--- hw/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
    import mcu16_pkg::*;
(
    input  logic   clk,
    input  logic   nreset,
    input  flags_t flags,
    decode_if.sink dec,
    exec_if.source res
);
    // Bit 16 holds the carry, borrow or shifted-out bit
    logic [WORD_W:0] wide;
    flags_t          new_flags;
    logic            taken;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD: wide = {1'b0, dec.operand_a} + {1'b0, dec.operand_b};
            ALU_SUB: wide = {1'b0, dec.operand_a} - {1'b0, dec.operand_b};
            ALU_AND: wide = {1'b0, dec.operand_a & dec.operand_b};
            ALU_OR:  wide = {1'b0, dec.operand_a | dec.operand_b};
            ALU_XOR: wide = {1'b0, dec.operand_a ^ dec.operand_b};
            ALU_SHL: wide = {dec.operand_a, 1'b0};
            ALU_SHR: wide = {dec.operand_a[0], 1'b0, dec.operand_a[WORD_W-1:1]};
            ALU_INC: wide = {1'b0, dec.operand_a} + 17'd1;
            ALU_DEC: wide = {1'b0, dec.operand_a} - 17'd1;
            ALU_NOT: wide = {1'b0, ~dec.operand_a};
            // Zero minus a borrows for any nonzero a
            ALU_NEG: wide = 17'd0 - {1'b0, dec.operand_a};
            default: wide = {1'b0, dec.operand_b};
        endcase
    end

    assign new_flags = {wide[WORD_W], wide[WORD_W-1:0] == '0, wide[WORD_W-1]};

    // Any flag under the mask passes and BRN inverts the test
    assign taken = dec.is_branch & ((|(dec.branch_mask & flags)) ^ dec.branch_neg);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= dec.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid) begin
            res.value        <= wide[WORD_W-1:0];
            res.rd           <= dec.rd;
            res.wr_en        <= dec.wr_en;
            res.new_flags    <= new_flags;
            res.flags_en     <= dec.flags_en;
            res.branch_taken <= taken;
            res.target       <= dec.target;
            res.is_out       <= dec.is_out;
            res.is_halt      <= dec.is_halt;
            res.is_illegal   <= dec.is_illegal;
        end
    end

    a_result_follows: assert property (@(posedge clk) disable iff (!nreset)
        dec.valid |=> res.valid && !dec.valid);

endmodule

//--- hw/mcu16_core.sv
`timescale 1ns/1ps

module mcu16_core
    import mcu16_pkg::*;
(
    input  logic  clk,
    input  logic  nreset,
    input  word_t instr_data,
    output pc_t   instr_addr,
    output logic  out_valid,
    output word_t out_data,
    output logic  halted,
    output logic  error
);
    reg_addr_t rs_addr;
    reg_addr_t rd_addr;
    word_t     rs_data;
    word_t     rd_data;
    flags_t    flags;
    logic      pc_load;
    pc_t       pc_target;
    logic      stop;

    decode_if dec_bus ();
    exec_if   exec_bus ();

    decode_unit u_decode (
        .clk        (clk),
        .nreset     (nreset),
        .instr_data (instr_data),
        .instr_addr (instr_addr),
        .rs_addr    (rs_addr),
        .rd_addr    (rd_addr),
        .rs_data    (rs_data),
        .rd_data    (rd_data),
        .pc_load    (pc_load),
        .pc_target  (pc_target),
        .stop       (stop),
        .dec        (dec_bus.source)
    );

    execute_unit u_execute (
        .clk    (clk),
        .nreset (nreset),
        .flags  (flags),
        .dec    (dec_bus.sink),
        .res    (exec_bus.source)
    );

    result_unit u_result (
        .clk       (clk),
        .nreset    (nreset),
        .res       (exec_bus.sink),
        .rs_addr   (rs_addr),
        .rd_addr   (rd_addr),
        .rs_data   (rs_data),
        .rd_data   (rd_data),
        .flags     (flags),
        .pc_load   (pc_load),
        .pc_target (pc_target),
        .stop      (stop),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halted    (halted),
        .error     (error)
    );

endmodule

//--- hw/mcu16_ifs.sv
`timescale 1ns/1ps

// Decoded instruction, presented to the execute unit
interface decode_if import mcu16_pkg::*; ();
    logic      valid;
    alu_op_t   alu_op;
    word_t     operand_a;
    word_t     operand_b;
    reg_addr_t rd;
    logic      wr_en;
    logic      flags_en;
    logic      is_branch;
    logic      branch_neg;
    flags_t    branch_mask;
    pc_t       target;
    logic      is_out;
    logic      is_halt;
    logic      is_illegal;

    modport source (output valid, alu_op, operand_a, operand_b, rd, wr_en, flags_en,
                    is_branch, branch_neg, branch_mask, target, is_out, is_halt, is_illegal);
    modport sink   (input valid, alu_op, operand_a, operand_b, rd, wr_en, flags_en,
                    is_branch, branch_neg, branch_mask, target, is_out, is_halt, is_illegal);
endinterface

// Executed result, waiting for commit in the result unit
interface exec_if import mcu16_pkg::*; ();
    logic      valid;
    word_t     value;
    reg_addr_t rd;
    logic      wr_en;
    flags_t    new_flags;
    logic      flags_en;
    logic      branch_taken;
    pc_t       target;
    logic      is_out;
    logic      is_halt;
    logic      is_illegal;

    modport source (output valid, value, rd, wr_en, new_flags, flags_en, branch_taken,
                    target, is_out, is_halt, is_illegal);
    modport sink   (input valid, value, rd, wr_en, new_flags, flags_en, branch_taken,
                    target, is_out, is_halt, is_illegal);
endinterface

//--- hw/mcu16_pkg.sv
package mcu16_pkg;

    localparam int WORD_W     = 16;
    localparam int PC_W       = 8;
    localparam int REG_ADDR_W = 3;
    localparam int OPCODE_W   = 5;
    localparam int ALU_OP_W   = 4;
    localparam int FLAG_W     = 3;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [ALU_OP_W-1:0]   alu_op_t;

    // Flag order is c, z, n from high to low, the same as the branch mask
    typedef logic [FLAG_W-1:0]     flags_t;

    localparam opcode_t OP_NOP = 5'd0;
    localparam opcode_t OP_LDI = 5'd1;
    localparam opcode_t OP_MOV = 5'd2;
    localparam opcode_t OP_ADD = 5'd3;
    localparam opcode_t OP_SUB = 5'd4;
    localparam opcode_t OP_AND = 5'd5;
    localparam opcode_t OP_OR  = 5'd6;
    localparam opcode_t OP_XOR = 5'd7;
    localparam opcode_t OP_CMP = 5'd8;
    localparam opcode_t OP_SHL = 5'd9;
    localparam opcode_t OP_SHR = 5'd10;
    localparam opcode_t OP_INC = 5'd11;
    localparam opcode_t OP_DEC = 5'd12;
    localparam opcode_t OP_NOT = 5'd13;
    localparam opcode_t OP_NEG = 5'd14;
    localparam opcode_t OP_BR  = 5'd15;
    localparam opcode_t OP_BRN = 5'd16;
    localparam opcode_t OP_OUT = 5'd17;
    localparam opcode_t OP_HLT = 5'd18;

    localparam alu_op_t ALU_PASS = 4'd0;
    localparam alu_op_t ALU_ADD  = 4'd1;
    localparam alu_op_t ALU_SUB  = 4'd2;
    localparam alu_op_t ALU_AND  = 4'd3;
    localparam alu_op_t ALU_OR   = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SHL  = 4'd6;
    localparam alu_op_t ALU_SHR  = 4'd7;
    localparam alu_op_t ALU_INC  = 4'd8;
    localparam alu_op_t ALU_DEC  = 4'd9;
    localparam alu_op_t ALU_NOT  = 4'd10;
    localparam alu_op_t ALU_NEG  = 4'd11;

    localparam int  RD_LSB    = 8;
    localparam int  RS_LSB    = 5;
    localparam int  REG_COUNT = 8;
    localparam pc_t RESET_PC  = 8'd0;

    typedef enum logic [1:0] {S_DECODE, S_EXECUTE, S_RESULT, S_STOPPED} seq_state_t;

endpackage

//--- hw/result_unit.sv
`timescale 1ns/1ps

module result_unit
    import mcu16_pkg::*;
(
    input  logic      clk,
    input  logic      nreset,
    exec_if.sink      res,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rd_addr,
    output word_t     rs_data,
    output word_t     rd_data,
    output flags_t    flags,
    output logic      pc_load,
    output pc_t       pc_target,
    output logic      stop,
    output logic      out_valid,
    output word_t     out_data,
    output logic      halted,
    output logic      error
);
    word_t regs [REG_COUNT];

    assign rs_data   = regs[rs_addr];
    assign rd_data   = regs[rd_addr];
    assign pc_load   = res.valid & res.branch_taken;
    assign pc_target = res.target;
    assign stop      = res.valid & (res.is_halt | res.is_illegal);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            flags     <= '0;
            out_valid <= 1'b0;
            halted    <= 1'b0;
            error     <= 1'b0;
        end else begin
            if (res.valid && res.wr_en) begin
                regs[res.rd] <= res.value;
            end
            if (res.valid && res.flags_en) begin
                flags <= res.new_flags;
            end
            out_valid <= res.valid & res.is_out;
            // Both status bits are sticky until the next reset
            if (res.valid && res.is_halt) begin
                halted <= 1'b1;
            end
            if (res.valid && res.is_illegal) begin
                error <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res.valid && res.is_out) begin
            out_data <= res.value;
        end
    end

    // Holds only if the sequencer really stops after HLT or an illegal opcode
    a_no_out_when_stopped: assert property (@(posedge clk) disable iff (!nreset)
        !(out_valid && (halted || error)));

endmodule

//--- testbench/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int NUM_TESTS = 7;
localparam int MAX_WORDS = 16;
localparam int MAX_OUTS  = 8;

// Branch masks in flag order c, z, n
localparam int MASK_C = 4;
localparam int MASK_Z = 2;
localparam int MASK_N = 1;

string test_name  [NUM_TESTS];
word_t prog_words [NUM_TESTS][MAX_WORDS];
int    prog_len   [NUM_TESTS];
word_t exp_out    [NUM_TESTS][MAX_OUTS];
int    exp_count  [NUM_TESTS];
logic  exp_error  [NUM_TESTS];

function automatic word_t rr_word(opcode_t op, int rd, int rs);
    return {op, 3'(rd), 3'(rs), 5'b0};
endfunction

function automatic word_t imm_word(opcode_t op, int field, int imm);
    return {op, 3'(field), 8'(imm)};
endfunction

task automatic append_word(int t, word_t w);
    prog_words[t][prog_len[t]] = w;
    prog_len[t]++;
endtask

task automatic expect_out(int t, word_t v);
    exp_out[t][exp_count[t]] = v;
    exp_count[t]++;
endtask

// Entries 0 to 4 are fixed, the last two are filled with LFSR operands later
task automatic build_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
        prog_len[t]  = 0;
        exp_count[t] = 0;
        exp_error[t] = 1'b0;
        for (int a = 0; a < MAX_WORDS; a++) begin
            prog_words[t][a] = '0;
        end
    end

    // The OUT placed after HLT must never show up
    test_name[0] = "ldi_mov_add_sub";
    append_word(0, imm_word(OP_LDI, 1, 'h85));
    append_word(0, rr_word(OP_OUT, 1, 0));
    append_word(0, imm_word(OP_LDI, 2, 'h12));
    append_word(0, rr_word(OP_MOV, 3, 2));
    append_word(0, rr_word(OP_OUT, 3, 0));
    append_word(0, rr_word(OP_ADD, 1, 2));
    append_word(0, rr_word(OP_OUT, 1, 0));
    append_word(0, rr_word(OP_SUB, 3, 1));
    append_word(0, rr_word(OP_OUT, 3, 0));
    append_word(0, rr_word(OP_HLT, 0, 0));
    append_word(0, rr_word(OP_OUT, 1, 0));
    expect_out(0, 16'hFF85);
    expect_out(0, 16'h0012);
    expect_out(0, 16'hFF97);
    expect_out(0, 16'h007B);

    test_name[1] = "unary_and_shift";
    append_word(1, imm_word(OP_LDI, 1, 'hFF));
    append_word(1, rr_word(OP_INC, 1, 0));
    append_word(1, rr_word(OP_OUT, 1, 0));
    append_word(1, rr_word(OP_DEC, 1, 0));
    append_word(1, rr_word(OP_OUT, 1, 0));
    append_word(1, rr_word(OP_SHR, 1, 0));
    append_word(1, rr_word(OP_OUT, 1, 0));
    append_word(1, rr_word(OP_NOT, 1, 0));
    append_word(1, rr_word(OP_OUT, 1, 0));
    append_word(1, rr_word(OP_NEG, 1, 0));
    append_word(1, rr_word(OP_OUT, 1, 0));
    append_word(1, rr_word(OP_SHL, 1, 0));
    append_word(1, rr_word(OP_OUT, 1, 0));
    append_word(1, rr_word(OP_NOT, 0, 0));
    append_word(1, rr_word(OP_OUT, 0, 0));
    append_word(1, rr_word(OP_HLT, 0, 0));
    expect_out(1, 16'h0000);
    expect_out(1, 16'hFFFF);
    expect_out(1, 16'h7FFF);
    expect_out(1, 16'h8000);
    expect_out(1, 16'h8000);
    expect_out(1, 16'h0000);
    expect_out(1, 16'hFFFF);

    // BRN at address 3 jumps back to 1 while z is clear
    test_name[2] = "countdown_loop";
    append_word(2, imm_word(OP_LDI, 1, 3));
    append_word(2, rr_word(OP_OUT, 1, 0));
    append_word(2, rr_word(OP_DEC, 1, 0));
    append_word(2, imm_word(OP_BRN, MASK_Z, -3));
    append_word(2, rr_word(OP_OUT, 1, 0));
    append_word(2, rr_word(OP_HLT, 0, 0));
    expect_out(2, 16'd3);
    expect_out(2, 16'd2);
    expect_out(2, 16'd1);
    expect_out(2, 16'd0);

    test_name[3] = "cmp_and_branch";
    append_word(3, imm_word(OP_LDI, 1, 5));
    append_word(3, imm_word(OP_LDI, 2, 7));
    append_word(3, rr_word(OP_CMP, 1, 2));
    append_word(3, imm_word(OP_BR, MASK_C, 1));
    append_word(3, rr_word(OP_OUT, 1, 0));
    append_word(3, imm_word(OP_BR, MASK_N, 1));
    append_word(3, rr_word(OP_OUT, 1, 0));
    append_word(3, rr_word(OP_OUT, 2, 0));
    append_word(3, rr_word(OP_CMP, 2, 1));
    append_word(3, imm_word(OP_BR, MASK_C, 1));
    append_word(3, rr_word(OP_OUT, 1, 0));
    append_word(3, imm_word(OP_BRN, MASK_N, 1));
    append_word(3, rr_word(OP_OUT, 1, 0));
    append_word(3, imm_word(OP_BR, MASK_N, 1));
    append_word(3, rr_word(OP_OUT, 2, 0));
    append_word(3, rr_word(OP_HLT, 0, 0));
    expect_out(3, 16'd7);
    expect_out(3, 16'd5);
    expect_out(3, 16'd7);

    // Opcode 31 is not assigned
    test_name[4] = "illegal_opcode";
    append_word(4, imm_word(OP_LDI, 1, 'h11));
    append_word(4, rr_word(OP_OUT, 1, 0));
    append_word(4, 16'hF800);
    append_word(4, rr_word(OP_OUT, 1, 0));
    append_word(4, rr_word(OP_HLT, 0, 0));
    expect_out(4, 16'h0011);
    exp_error[4] = 1'b1;
endtask

`endif

//--- testbench/tb_mcu16.sv
`timescale 1ns/1ps

module tb_mcu16
    import mcu16_pkg::*;
();
    localparam int RESET_CYCLES = 3;
    localparam int WATCH_CYCLES = 12;
    localparam int INSTR_BUDGET = 20;
    localparam int NUM_FIXED    = 5;

    logic  clk;
    logic  nreset;
    word_t instr_data;
    pc_t   instr_addr;
    logic  out_valid;
    word_t out_data;
    logic  halted;
    logic  error;

    int          cur_test;
    int          error_count;
    int          failed_tests;
    int          cycle_count;
    logic [15:0] lfsr_state;

    `include "tb_programs.svh"

    localparam int CYCLE_LIMIT =
        NUM_TESTS * (3 * INSTR_BUDGET + RESET_CYCLES + WATCH_CYCLES) + 50;

    mcu16_core uut (
        .clk        (clk),
        .nreset     (nreset),
        .instr_data (instr_data),
        .instr_addr (instr_addr),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .halted     (halted),
        .error      (error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Program ROM model, addresses past the table read as NOP
    always @(negedge clk) begin
        if (int'(instr_addr) < MAX_WORDS) begin
            instr_data <= prog_words[cur_test][instr_addr[3:0]];
        end else begin
            instr_data <= '0;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the core did not finish within %0d cycles", cycle_count);
        $display("Checks failed");
        $finish;
    end

    // Galois LFSR, taps 16, 14, 13, 11
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out_bit;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        for (int i = 0; i < 8; i++) begin
            value[i] = next_random_bit();
        end
        return value;
    endfunction

    function automatic word_t alu_model(opcode_t op, word_t a, word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            default: return b;
        endcase
    endfunction

    task automatic fill_random(int t);
        opcode_t    ops [3] = '{OP_ADD, OP_SUB, OP_AND};
        logic [7:0] imm_a;
        logic [7:0] imm_b;
        word_t      a;
        word_t      b;
        imm_a = random_byte();
        imm_b = random_byte();
        a = {{8{imm_a[7]}}, imm_a};
        b = {{8{imm_b[7]}}, imm_b};
        test_name[t] = $sformatf("random_%02h_%02h", imm_a, imm_b);
        append_word(t, imm_word(OP_LDI, 1, imm_a));
        append_word(t, imm_word(OP_LDI, 2, imm_b));
        for (int i = 0; i < 3; i++) begin
            append_word(t, rr_word(OP_MOV, 3, 1));
            append_word(t, rr_word(ops[i], 3, 2));
            append_word(t, rr_word(OP_OUT, 3, 0));
            expect_out(t, alu_model(ops[i], a, b));
        end
        // OR overwrites r2, so the XOR sees the OR result
        append_word(t, rr_word(OP_OR, 2, 1));
        append_word(t, rr_word(OP_OUT, 2, 0));
        expect_out(t, alu_model(OP_OR, b, a));
        append_word(t, rr_word(OP_XOR, 1, 2));
        append_word(t, rr_word(OP_OUT, 1, 0));
        expect_out(t, alu_model(OP_XOR, a, alu_model(OP_OR, b, a)));
        append_word(t, rr_word(OP_HLT, 0, 0));
    endtask

    task automatic run_test(int t);
        word_t got [MAX_OUTS];
        int    n_out;
        int    errors_before;
        pc_t   stop_addr;
        errors_before = error_count;
        @(negedge clk);
        cur_test = t;
        nreset = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        assert (!out_valid && !halted && !error && instr_addr == RESET_PC) else begin
            $display("[ERROR] %0t: test %0d status high or fetch address %0d in reset",
                     $time, t, instr_addr);
            error_count++;
        end
        nreset = 1'b1;

        n_out = 0;
        while (!halted && !error) begin
            @(negedge clk);
            if (out_valid) begin
                if (n_out < MAX_OUTS) begin
                    got[n_out] = out_data;
                end
                n_out++;
            end
        end

        assert (n_out == exp_count[t]) else begin
            $display("[ERROR] %0t: test %0d gave %0d outputs, expected %0d",
                     $time, t, n_out, exp_count[t]);
            error_count++;
        end
        for (int i = 0; i < n_out && i < exp_count[t] && i < MAX_OUTS; i++) begin
            assert (got[i] == exp_out[t][i]) else begin
                $display("[ERROR] %0t: test %0d output %0d is %h, expected %h",
                         $time, t, i, got[i], exp_out[t][i]);
                error_count++;
            end
        end
        assert (error == exp_error[t] && halted == !exp_error[t]) else begin
            $display("[ERROR] %0t: test %0d ended with halted=%0b error=%0b",
                     $time, t, halted, error);
            error_count++;
        end

        // A stopped core must stay put until the next reset
        stop_addr = instr_addr;
        repeat (WATCH_CYCLES) begin
            @(negedge clk);
            assert (!out_valid && instr_addr == stop_addr) else begin
                $display("[ERROR] %0t: test %0d still running after stop, instr_addr %0d",
                         $time, t, instr_addr);
                error_count++;
            end
        end

        if (error_count == errors_before) begin
            $display("Test %0d %s: pass, %0d outputs", t, test_name[t], n_out);
        end else begin
            failed_tests++;
            $display("Test %0d %s: FAIL, %0d errors", t, test_name[t],
                     error_count - errors_before);
        end
    endtask

    initial begin
        nreset       = 1'b0;
        instr_data   = '0;
        cur_test     = 0;
        error_count  = 0;
        failed_tests = 0;
        lfsr_state   = 16'd55659;
        build_table();
        for (int t = NUM_FIXED; t < NUM_TESTS; t++) begin
            fill_random(t);
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests: %0d run, %0d failed, %0d errors", NUM_TESTS, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
